/* project.f */
ffcp_pkg.sv
rmii_byte_rx.sv
eth_frame_rx.sv
packet_buffer.sv
fgp_video_writer.sv
ffcp_video_rx.sv
ffcp_video_rx_assert.sv
ffcp_video_rx_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FFCP video receive testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module ffcp_video_rx_tb \
	-f project.f \
	-o sim_ffcp_video_rx

./obj_dir/sim_ffcp_video_rx 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

/* ffcp_video_rx_tb.sv */
`default_nettype none

module ffcp_video_rx_tb
	import ffcp_pkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	localparam int PIX_CREDITS = 4;
	localparam int NUM_FRAMES = 13;
	localparam int DRAIN_LIMIT = 1500;

	localparam int KIND_GOOD = 0;
	localparam int KIND_BAD_ETHERTYPE = 1;
	localparam int KIND_BAD_TYPE = 2;
	localparam int KIND_RXERR = 3;
	localparam int KIND_SHORT = 4;
	localparam int KIND_LONG = 5;

	logic clk;
	logic eth_rx_downstream_rst;
	logic rmii_crsdv;
	logic [1:0] rmii_rxd;
	logic rmii_rxerr;
	logic pix_credit;
	logic pix_valid;
	vram_addr_t pix_addr;
	color_t pix_data;

	byte_t fgp [FGP_LEN];
	logic [22:0] exp_q [$];
	ffcp_index_t next_idx;
	string test_name;
	logic hold_credits;
	int cmp_err = 0;
	int chk_err = 0;
	int test_err_base;
	int pass_cnt;
	int fail_cnt;
	int pix_seen = 0;
	int credits_back = 0;
	int stall_base;

	ffcp_video_rx #(.QUEUE_DEPTH(QUEUE_DEPTH), .PIX_CREDITS(PIX_CREDITS)) ffcp_video_rx_i (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii_crsdv(rmii_crsdv), .rmii_rxd(rmii_rxd), .rmii_rxerr(rmii_rxerr),
		.pix_credit(pix_credit), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_data(pix_data));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Pixel n of an FGP as {address, color}, two colors per three data bytes
	function automatic logic [22:0] expected_pixel(input byte_t f [FGP_LEN], input int n);
		byte_t b0;
		byte_t b1;
		byte_t b2;
		vram_addr_t addr;
		color_t color;
		b0 = f[1 + 3 * (n / 2)];
		b1 = f[2 + 3 * (n / 2)];
		b2 = f[3 + 3 * (n / 2)];
		addr = vram_addr_t'(int'(f[0]) * COLORS_PER_FGP + n);
		if (n % 2 == 0)
			color = {b0, b1[7:4]};
		else
			color = {b1[3:0], b2};
		return {addr, color};
	endfunction

	task automatic send_frame(input ffcp_index_t idx, input int kind);
		byte_t frame_bytes [$];
		byte_t cur;
		int i;
		int k;
		for (i = 0; i < 7; i++)
			frame_bytes.push_back(8'h55);
		frame_bytes.push_back(SFD_BYTE);
		for (i = 0; i < 12; i++)
			frame_bytes.push_back(i < 6 ? 8'hFF : byte_t'(8'h10 + i));
		if (kind == KIND_BAD_ETHERTYPE) begin
			frame_bytes.push_back(8'h08);
			frame_bytes.push_back(8'h00);
		end else begin
			frame_bytes.push_back(ETHERTYPE_FFCP[15:8]);
			frame_bytes.push_back(ETHERTYPE_FFCP[7:0]);
		end
		frame_bytes.push_back(kind == KIND_BAD_TYPE ? 8'h01 : FFCP_TYPE_MSG);
		frame_bytes.push_back(idx);
		for (i = 0; i < FGP_LEN; i++)
			if (kind != KIND_SHORT || i < FGP_LEN - 1)
				frame_bytes.push_back(fgp[i]);
		if (kind == KIND_LONG)
			frame_bytes.push_back(byte_t'($urandom));
		// Low dibit first, RXERR lands inside the FGP
		for (i = 0; i < frame_bytes.size(); i++) begin
			cur = frame_bytes[i];
			for (k = 0; k < 4; k++) begin
				@(posedge clk);
				#1;
				rmii_crsdv = 1'b1;
				rmii_rxd = cur[2*k +: 2];
				rmii_rxerr = kind == KIND_RXERR && i == 30 && k == 1;
			end
		end
		@(posedge clk);
		#1;
		rmii_crsdv = 1'b0;
		rmii_rxd = 2'b00;
		rmii_rxerr = 1'b0;
		repeat (11) @(posedge clk);
	endtask

	task automatic run_frame(input int kind, input ffcp_index_t idx, input logic accepted);
		int n;
		for (n = 0; n < FGP_LEN; n++)
			fgp[n] = byte_t'($urandom);
		// Pixels may start before the carrier gap is over
		if (accepted) begin
			for (n = 0; n < COLORS_PER_FGP; n++)
				exp_q.push_back(expected_pixel(fgp, n));
			next_idx++;
		end
		send_frame(idx, kind);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_base = cmp_err + chk_err;
	endtask

	task automatic finish_test;
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || pix_seen != credits_back) && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Test %s: %0d expected pixels never came out", test_name, exp_q.size());
			chk_err++;
			exp_q.delete();
		end
		// Quiet spell catches stray pixels
		repeat (40) @(posedge clk);
		if (cmp_err + chk_err == test_err_base) begin
			pass_cnt++;
			$display("Test %s passed", test_name);
		end else begin
			fail_cnt++;
			$display("Test %s failed with %0d errors", test_name,
				cmp_err + chk_err - test_err_base);
		end
	endtask

	always @(negedge clk) begin : compare_pixels
		logic [22:0] exp_pix;
		if (!eth_rx_downstream_rst && pix_valid) begin
			pix_seen++;
			if (exp_q.size() == 0) begin
				$display("Test %s: unexpected pixel at address %0d color %03h",
					test_name, pix_addr, pix_data);
				cmp_err++;
			end else begin
				exp_pix = exp_q.pop_front();
				if ({pix_addr, pix_data} != exp_pix) begin
					$display("Mismatch in %s: expected address %0d color %03h, actual address %0d color %03h",
						test_name, exp_pix[22:12], exp_pix[11:0], pix_addr, pix_data);
					cmp_err++;
				end
			end
		end
	end

	initial begin : return_credits
		int unsigned delay;
		pix_credit = 1'b0;
		forever begin
			@(posedge clk);
			if (!hold_credits && pix_seen > credits_back) begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge clk);
				#1;
				pix_credit = 1'b1;
				credits_back++;
				@(posedge clk);
				#1;
				pix_credit = 1'b0;
			end
		end
	end

	initial begin
		repeat (NUM_FRAMES * 400 + 2000) @(posedge clk);
		$display("Watchdog expired before all tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		eth_rx_downstream_rst = 1'b1;
		rmii_crsdv = 1'b0;
		rmii_rxd = 2'b00;
		rmii_rxerr = 1'b0;
		hold_credits = 1'b0;
		next_idx = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		void'($urandom(32'h685c6605));
		repeat (5) @(posedge clk);
		#1;
		eth_rx_downstream_rst = 1'b0;

		start_test("single_frame");
		run_frame(KIND_GOOD, next_idx, 1'b1);
		finish_test();

		start_test("bad_ethertype_or_type");
		run_frame(KIND_BAD_ETHERTYPE, next_idx, 1'b0);
		run_frame(KIND_BAD_TYPE, next_idx, 1'b0);
		run_frame(KIND_GOOD, next_idx, 1'b1);
		finish_test();

		start_test("bad_index_or_rxerr");
		run_frame(KIND_GOOD, next_idx + 8'd5, 1'b0);
		run_frame(KIND_RXERR, next_idx, 1'b0);
		run_frame(KIND_GOOD, next_idx, 1'b1);
		finish_test();

		start_test("wrong_length");
		run_frame(KIND_SHORT, next_idx, 1'b0);
		run_frame(KIND_LONG, next_idx, 1'b0);
		run_frame(KIND_GOOD, next_idx, 1'b1);
		finish_test();

		start_test("credit_stall");
		hold_credits = 1'b1;
		stall_base = pix_seen;
		repeat (3) run_frame(KIND_GOOD, next_idx, 1'b1);
		if (pix_seen - stall_base > PIX_CREDITS) begin
			$display("Test %s: %0d pixels came out while credits were held back",
				test_name, pix_seen - stall_base);
			chk_err++;
		end
		hold_credits = 1'b0;
		finish_test();

		$display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt,
			cmp_err + chk_err);
		if (fail_cnt == 0 && cmp_err + chk_err == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* ffcp_video_rx_assert.sv */
`default_nettype none

module ffcp_video_rx_assert
	import ffcp_pkg::*;
#(
	parameter int PIX_CREDITS = 4
) (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire pix_valid,
	input wire vram_addr_t pix_addr,
	input wire byte_t offset,
	input wire [$clog2(PIX_CREDITS + 1)-1:0] credit_cnt
);

	logic [$clog2(COLORS_PER_FGP)-1:0] pix_cnt;

	// Pixel number inside the current FGP
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst)
			pix_cnt <= '0;
		else if (pix_valid)
			pix_cnt <= pix_cnt + 1'b1;
	end

	no_pixel_without_credit: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		pix_valid |-> credit_cnt != '0)
		else $error("pix_valid high with no credit left");

	credit_limit: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		int'(credit_cnt) <= PIX_CREDITS)
		else $error("credit count above %0d", PIX_CREDITS);

	// Pixels of an FGP go to offset times eight plus their position
	addr_in_range: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		pix_valid |-> int'(pix_addr) == int'(offset) * COLORS_PER_FGP + int'(pix_cnt))
		else $error("pixel address %0d not at position %0d of its FGP", pix_addr, pix_cnt);

endmodule

bind fgp_video_writer ffcp_video_rx_assert #(.PIX_CREDITS(PIX_CREDITS)) ffcp_video_rx_assert_i (
	.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
	.pix_valid(pix_valid), .pix_addr(pix_addr), .offset(offset),
	.credit_cnt(credit_cnt));

`default_nettype wire

/* ffcp_video_rx.sv */
`default_nettype none

module ffcp_video_rx
	import ffcp_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4,
	parameter int PIX_CREDITS = 4
) (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire rmii_crsdv,
	input wire [1:0] rmii_rxd,
	input wire rmii_rxerr,
	input wire pix_credit,
	output logic pix_valid,
	output vram_addr_t pix_addr,
	output color_t pix_data
);

	logic byte_valid;
	byte_t byte_data;
	logic frame_end;
	logic frame_err;

	logic pl_valid;
	byte_t pl_data;
	ffcp_index_t pl_index;
	logic pl_last;
	logic pl_drop;
	ffcp_index_t exp_index;

	logic slot_ready;
	logic rd_req;
	fgp_cnt_t rd_pos;
	byte_t rd_data;
	logic slot_release;

	rmii_byte_rx rmii_byte_rx_i (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii_crsdv(rmii_crsdv), .rmii_rxd(rmii_rxd), .rmii_rxerr(rmii_rxerr),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.frame_end(frame_end), .frame_err(frame_err));

	eth_frame_rx eth_frame_rx_i (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.frame_end(frame_end), .frame_err(frame_err), .exp_index(exp_index),
		.pl_valid(pl_valid), .pl_data(pl_data), .pl_index(pl_index),
		.pl_last(pl_last), .pl_drop(pl_drop));

	packet_buffer #(.QUEUE_DEPTH(QUEUE_DEPTH)) packet_buffer_i (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.pl_valid(pl_valid), .pl_data(pl_data), .pl_index(pl_index),
		.pl_last(pl_last), .pl_drop(pl_drop),
		.rd_req(rd_req), .rd_pos(rd_pos), .slot_release(slot_release),
		.exp_index(exp_index), .slot_ready(slot_ready), .rd_data(rd_data));

	fgp_video_writer #(.PIX_CREDITS(PIX_CREDITS)) fgp_video_writer_i (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.slot_ready(slot_ready), .rd_data(rd_data), .pix_credit(pix_credit),
		.rd_req(rd_req), .rd_pos(rd_pos), .slot_release(slot_release),
		.pix_valid(pix_valid), .pix_addr(pix_addr), .pix_data(pix_data));

endmodule

`default_nettype wire

/* fgp_video_writer.sv */
`default_nettype none

module fgp_video_writer
	import ffcp_pkg::*;
#(
	parameter int PIX_CREDITS = 4
) (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire slot_ready,
	input wire byte_t rd_data,
	input wire pix_credit,
	output logic rd_req,
	output fgp_cnt_t rd_pos,
	output logic slot_release,
	output logic pix_valid,
	output vram_addr_t pix_addr,
	output color_t pix_data
);

	localparam int CREDIT_W = $clog2(PIX_CREDITS + 1);

	wr_state_t state;
	logic [CREDIT_W-1:0] credit_cnt;
	logic [1:0] req_phase;
	logic rsp_valid;
	logic [1:0] rsp_phase;
	logic rsp_cplt;
	logic credit_ok;
	logic last_color;
	byte_t offset;
	byte_t carry;
	logic [2:0] pix_num;

	// Phase 0 of a byte triple completes no color, phases 1 and 2 complete one
	assign rsp_cplt = rsp_valid && state == WR_DATA && rsp_phase != 2'd0;

	// Colors already on their way still hold a credit
	assign credit_ok = int'(credit_cnt) > int'(rsp_cplt) + int'(pix_valid);

	assign last_color = rsp_cplt && pix_num == 3'(COLORS_PER_FGP - 1);
	assign slot_release = last_color;

	always_comb begin
		case (state)
			WR_IDLE: rd_req = slot_ready;
			WR_DATA: rd_req = rd_pos <= fgp_cnt_t'(FGP_DATA_LEN) &&
				(req_phase == 2'd0 || credit_ok);
			default: rd_req = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == WR_OFFSET)
			offset <= rd_data;
		if (rsp_valid && state == WR_DATA) begin
			case (rsp_phase)
				2'd0: carry <= rd_data;
				2'd1: begin
					pix_data <= {carry, rd_data[7:4]};
					carry <= {4'h0, rd_data[3:0]};
				end
				default: pix_data <= {carry[3:0], rd_data};
			endcase
		end
		if (rsp_cplt)
			pix_addr <= {offset, pix_num};
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= WR_IDLE;
			credit_cnt <= CREDIT_W'(PIX_CREDITS);
			rd_pos <= '0;
			req_phase <= 2'd0;
			rsp_valid <= 1'b0;
			rsp_phase <= 2'd0;
			pix_num <= 3'd0;
			pix_valid <= 1'b0;
		end else begin
			rsp_valid <= rd_req;
			rsp_phase <= req_phase;
			pix_valid <= rsp_cplt;
			credit_cnt <= credit_cnt - CREDIT_W'(pix_valid) + CREDIT_W'(pix_credit);
			if (rd_req) begin
				rd_pos <= rd_pos + 1'b1;
				if (state == WR_DATA)
					req_phase <= (req_phase == 2'd2) ? 2'd0 : req_phase + 2'd1;
			end
			if (rsp_cplt)
				pix_num <= pix_num + 3'd1;
			case (state)
				WR_IDLE: begin
					if (slot_ready)
						state <= WR_OFFSET;
				end
				WR_OFFSET: state <= WR_DATA;
				WR_DATA: begin
					if (last_color) begin
						state <= WR_IDLE;
						rd_pos <= '0;
						req_phase <= 2'd0;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* packet_buffer.sv */
`default_nettype none

module packet_buffer
	import ffcp_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire pl_valid,
	input wire byte_t pl_data,
	input wire ffcp_index_t pl_index,
	input wire pl_last,
	input wire pl_drop,
	input wire rd_req,
	input wire fgp_cnt_t rd_pos,
	input wire slot_release,
	output ffcp_index_t exp_index,
	output logic slot_ready,
	output byte_t rd_data
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int SLOT_WORDS = 2 ** $bits(fgp_cnt_t);

	byte_t mem [QUEUE_DEPTH*SLOT_WORDS];

	// Extra top bit tells full from empty
	logic [PTR_W:0] head;
	logic [PTR_W:0] tail;
	fgp_cnt_t wr_pos;
	logic wr_blocked;
	logic full;
	logic commit;

	assign full = (head[PTR_W] != tail[PTR_W]) &&
		(head[PTR_W-1:0] == tail[PTR_W-1:0]);

	// A frame that lost bytes to a full queue is never committed
	assign commit = pl_last && !full && !wr_blocked;

	assign slot_ready = head != tail;

	always_ff @(posedge clk) begin
		if (pl_valid && !full)
			mem[{tail[PTR_W-1:0], wr_pos}] <= pl_data;
	end

	always_ff @(posedge clk) begin
		if (rd_req)
			rd_data <= mem[{head[PTR_W-1:0], rd_pos}];
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			head <= '0;
			tail <= '0;
			wr_pos <= '0;
			wr_blocked <= 1'b0;
			exp_index <= '0;
		end else begin
			if (pl_last || pl_drop) begin
				wr_pos <= '0;
				wr_blocked <= 1'b0;
			end else if (pl_valid) begin
				if (full)
					wr_blocked <= 1'b1;
				else
					wr_pos <= wr_pos + 1'b1;
			end
			if (commit) begin
				tail <= tail + 1'b1;
				exp_index <= pl_index + 1'b1;
			end
			if (slot_release && slot_ready)
				head <= head + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* eth_frame_rx.sv */
`default_nettype none

module eth_frame_rx
	import ffcp_pkg::*;
(
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire byte_valid,
	input wire byte_t byte_data,
	input wire frame_end,
	input wire frame_err,
	input wire ffcp_index_t exp_index,
	output logic pl_valid,
	output byte_t pl_data,
	output ffcp_index_t pl_index,
	output logic pl_last,
	output logic pl_drop
);

	localparam int HDR_CNT_W = $clog2(ETH_HEADER_LEN);

	rx_state_t state;
	logic [HDR_CNT_W-1:0] hdr_cnt;
	byte_t ethertype_hi;
	logic type_seen;
	fgp_cnt_t pl_cnt;

	always_ff @(posedge clk) begin
		if (byte_valid)
			pl_data <= byte_data;
		if (byte_valid && state == RX_HEADER && hdr_cnt == HDR_CNT_W'(ETH_HEADER_LEN - 2))
			ethertype_hi <= byte_data;
		if (byte_valid && state == RX_FFCP_HDR && type_seen)
			pl_index <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= RX_IDLE;
			hdr_cnt <= '0;
			type_seen <= 1'b0;
			pl_cnt <= '0;
			pl_valid <= 1'b0;
			pl_last <= 1'b0;
			pl_drop <= 1'b0;
		end else begin
			pl_valid <= 1'b0;
			pl_last <= 1'b0;
			pl_drop <= 1'b0;
			if (frame_end) begin
				// Commit only a clean frame of exactly one FGP
				if (state == RX_PAYLOAD && pl_cnt == fgp_cnt_t'(FGP_LEN) && !frame_err)
					pl_last <= 1'b1;
				else
					pl_drop <= 1'b1;
				state <= RX_IDLE;
				hdr_cnt <= '0;
				type_seen <= 1'b0;
				pl_cnt <= '0;
			end else if (byte_valid) begin
				case (state)
					RX_IDLE: begin
						hdr_cnt <= HDR_CNT_W'(1);
						state <= RX_HEADER;
					end
					RX_HEADER: begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == HDR_CNT_W'(ETH_HEADER_LEN - 1)) begin
							if ({ethertype_hi, byte_data} == ETHERTYPE_FFCP)
								state <= RX_FFCP_HDR;
							else
								state <= RX_DISCARD;
						end
					end
					RX_FFCP_HDR: begin
						type_seen <= 1'b1;
						if (!type_seen) begin
							if (byte_data != FFCP_TYPE_MSG)
								state <= RX_DISCARD;
						end else if (byte_data == exp_index) begin
							state <= RX_PAYLOAD;
						end else begin
							state <= RX_DISCARD;
						end
					end
					RX_PAYLOAD: begin
						// Too long, stop forwarding before the slot overflows
						if (pl_cnt == fgp_cnt_t'(FGP_LEN)) begin
							state <= RX_DISCARD;
						end else begin
							pl_valid <= 1'b1;
							pl_cnt <= pl_cnt + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rmii_byte_rx.sv */
`default_nettype none

module rmii_byte_rx
	import ffcp_pkg::*;
(
	input wire clk,
	input wire eth_rx_downstream_rst,
	input wire rmii_crsdv,
	input wire [1:0] rmii_rxd,
	input wire rmii_rxerr,
	output logic byte_valid,
	output byte_t byte_data,
	output logic frame_end,
	output logic frame_err
);

	byte_t shift_reg;
	byte_t shift_next;
	logic [1:0] dibit_cnt;
	logic synced;
	logic crsdv_q;
	logic err_seen;

	// Least significant dibit arrives first
	assign shift_next = {rmii_rxd, shift_reg[7:2]};

	always_ff @(posedge clk) begin
		if (rmii_crsdv)
			shift_reg <= shift_next;
		if (rmii_crsdv && synced && dibit_cnt == 2'd3)
			byte_data <= shift_next;
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			dibit_cnt <= 2'd0;
			synced <= 1'b0;
			crsdv_q <= 1'b0;
			err_seen <= 1'b0;
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			crsdv_q <= rmii_crsdv;
			byte_valid <= 1'b0;
			frame_end <= crsdv_q && !rmii_crsdv;
			frame_err <= crsdv_q && !rmii_crsdv && err_seen;
			if (rmii_crsdv) begin
				if (rmii_rxerr)
					err_seen <= 1'b1;
				if (!synced) begin
					// Hunt for the delimiter, byte alignment follows from it
					if (shift_next == SFD_BYTE) begin
						synced <= 1'b1;
						dibit_cnt <= 2'd0;
					end
				end else begin
					dibit_cnt <= dibit_cnt + 2'd1;
					if (dibit_cnt == 2'd3)
						byte_valid <= 1'b1;
				end
			end else begin
				synced <= 1'b0;
				dibit_cnt <= 2'd0;
				err_seen <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* ffcp_pkg.sv */
`default_nettype none

package ffcp_pkg;

	localparam int BYTE_LEN = 8;

	// Destination, source and EtherType
	localparam int ETH_HEADER_LEN = 14;

	localparam logic [15:0] ETHERTYPE_FFCP = 16'h1002;
	localparam logic [7:0] FFCP_TYPE_MSG = 8'h02;

	// FGP is one offset byte followed by the color data
	localparam int FGP_DATA_LEN = 12;
	localparam int FGP_LEN = 13;
	localparam int COLORS_PER_FGP = 8;

	localparam logic [7:0] SFD_BYTE = 8'hD5;

	typedef logic [BYTE_LEN-1:0] byte_t;
	typedef logic [7:0] ffcp_index_t;

	// Red in the top nibble, then green, then blue
	typedef logic [11:0] color_t;

	// Offset times COLORS_PER_FGP plus the pixel number
	typedef logic [10:0] vram_addr_t;

	typedef logic [3:0] fgp_cnt_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_HEADER,
		RX_FFCP_HDR,
		RX_PAYLOAD,
		RX_DISCARD
	} rx_state_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_OFFSET,
		WR_DATA
	} wr_state_t;

endpackage

`default_nettype wire
